// ==== src/rv_pipe_pkg.sv ====
package rv_pipe_pkg;

    // datapath sizes
    localparam int xlen        = 32;
    localparam int reg_addr_w  = 5;
    localparam int dmem_words  = 16;
    localparam int dmem_addr_w = 4;

    // major opcodes of the supported subset
    localparam logic [6:0] op_load  = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;
    localparam logic [6:0] op_reg   = 7'b0110011;
    localparam logic [6:0] op_imm   = 7'b0010011;

    // alu selects, shared by register and immediate forms
    localparam logic [2:0] funct3_add = 3'b000;
    localparam logic [2:0] funct3_xor = 3'b100;
    localparam logic [2:0] funct3_or  = 3'b110;
    localparam logic [2:0] funct3_and = 3'b111;

    // funct7 that turns add into sub
    localparam logic [6:0] funct7_sub = 7'b0100000;

    // one instruction word with two field layouts
    // the I-type immediate sits in the funct7 and rs2 bits of the R view
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [reg_addr_w-1:0] rs2;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } ri;
        // store layout, immediate split around rs1/rs2
        struct packed {
            logic [6:0]            imm_hi;
            logic [reg_addr_w-1:0] rs2;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [4:0]            imm_lo;
            logic [6:0]            opcode;
        } s;
    } instr_t;

endpackage

// ==== src/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage
    import rv_pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  instr_t                in_instr,
    input  logic                  stall,
    input  logic                  wb_valid,
    input  logic [reg_addr_w-1:0] wb_rd,
    input  logic [xlen-1:0]       wb_data,
    output logic                  in_ready,
    output logic [reg_addr_w-1:0] dec_rs1,
    output logic [reg_addr_w-1:0] dec_rs2,
    output logic [6:0]            dec_opcode,
    output logic                  id_ex_valid,
    output logic [6:0]            id_ex_opcode,
    output logic [2:0]            id_ex_funct3,
    output logic                  id_ex_sub,
    output logic [reg_addr_w-1:0] id_ex_rs1,
    output logic [reg_addr_w-1:0] id_ex_rs2,
    output logic [reg_addr_w-1:0] id_ex_rd,
    output logic                  id_ex_wr_reg_n,
    output logic [xlen-1:0]       id_ex_a,
    output logic [xlen-1:0]       id_ex_b,
    output logic [xlen-1:0]       id_ex_imm
);

    // x1..x31 only since x0 is hardwired
    logic [xlen-1:0] regs [1:2**reg_addr_w-1];
    logic            accept;
    logic            is_reg, is_addi, is_load, is_store;
    logic            use_rs1, use_rs2, writes_rd;
    logic [xlen-1:0] imm_i, imm_s, rd_a, rd_b;

    assign in_ready = ~stall;
    assign accept   = in_valid & in_ready;

    assign dec_opcode = in_instr.ri.opcode;
    assign is_reg     = dec_opcode == op_reg;
    assign is_addi    = dec_opcode == op_imm && in_instr.ri.funct3 == funct3_add;
    assign is_load    = dec_opcode == op_load;
    assign is_store   = dec_opcode == op_store;
    // anything else decodes as a no-op
    assign use_rs1    = is_reg | is_addi | is_load | is_store;
    assign use_rs2    = is_reg | is_store;
    assign writes_rd  = (is_reg | is_addi | is_load) && in_instr.ri.rd != '0;

    // unused sources read as x0 so they never match a hazard
    assign dec_rs1 = (in_valid && use_rs1) ? in_instr.ri.rs1 : '0;
    assign dec_rs2 = (in_valid && use_rs2) ? in_instr.ri.rs2 : '0;

    assign imm_i = {{(xlen-12){in_instr.ri.funct7[6]}}, in_instr.ri.funct7, in_instr.ri.rs2};
    assign imm_s = {{(xlen-12){in_instr.s.imm_hi[6]}}, in_instr.s.imm_hi, in_instr.s.imm_lo};

    // register read bypasses a write-back landing this cycle
    assign rd_a = (dec_rs1 == '0) ? '0 :
                  (wb_valid && wb_rd == dec_rs1) ? wb_data : regs[dec_rs1];
    assign rd_b = (dec_rs2 == '0) ? '0 :
                  (wb_valid && wb_rd == dec_rs2) ? wb_data : regs[dec_rs2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 2**reg_addr_w; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // bubble when stalled or idle
    always_ff @(posedge clk) begin
        if (rst) begin
            id_ex_valid    <= 1'b0;
            id_ex_wr_reg_n <= 1'b1;
        end else begin
            id_ex_valid    <= accept;
            id_ex_wr_reg_n <= ~(accept & writes_rd);
        end
    end

    always_ff @(posedge clk) begin
        id_ex_opcode <= dec_opcode;
        id_ex_funct3 <= in_instr.ri.funct3;
        id_ex_sub    <= is_reg && in_instr.ri.funct7 == funct7_sub;
        id_ex_rs1    <= dec_rs1;
        id_ex_rs2    <= dec_rs2;
        id_ex_rd     <= in_instr.ri.rd;
        id_ex_a      <= rd_a;
        id_ex_b      <= rd_b;
        id_ex_imm    <= is_store ? imm_s : imm_i;
    end

    // a stall needs a real offer and a valid load ahead and lasts one cycle
    a_stall_one_cycle: assert property (@(posedge clk) disable iff (rst)
        stall |-> in_valid && id_ex_valid ##1 !stall);

endmodule

// ==== src/stall_detector.sv ====
`timescale 1ns/1ps

module stall_detector
    import rv_pipe_pkg::*;
(
    input  logic [reg_addr_w-1:0] dec_rs1,
    input  logic [reg_addr_w-1:0] dec_rs2,
    input  logic [6:0]            dec_opcode,
    input  logic                  id_ex_valid,
    input  logic                  id_ex_wr_reg_n,
    input  logic [reg_addr_w-1:0] id_ex_rd,
    input  logic [6:0]            id_ex_opcode,
    output logic                  stall
);

    logic load_in_ex;
    logic store_in_dec;
    logic rs1_hit;
    logic rs2_hit;

    // only a real load that writes a register can cause a hazard
    // bubbles and rd == x0 loads fall out here
    assign load_in_ex = id_ex_valid && !id_ex_wr_reg_n && id_ex_opcode == op_load;

    assign store_in_dec = dec_opcode == op_store;

    // x0 is never produced, so a zero source never waits
    assign rs1_hit = dec_rs1 != '0 && dec_rs1 == id_ex_rd;
    assign rs2_hit = dec_rs2 != '0 && dec_rs2 == id_ex_rd;

    // load-use rules:
    // - rs1 match always stalls, the address is needed in execute
    // - rs2 match stalls everything except a store
    //   store data catches up from the write-back port in the memory stage
    // alu producers never stall, forwarding covers them
    assign stall = load_in_ex && (rs1_hit || (rs2_hit && !store_in_dec));

endmodule

// ==== src/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage
    import rv_pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  id_ex_valid,
    input  logic [6:0]            id_ex_opcode,
    input  logic [2:0]            id_ex_funct3,
    input  logic                  id_ex_sub,
    input  logic [reg_addr_w-1:0] id_ex_rs1,
    input  logic [reg_addr_w-1:0] id_ex_rs2,
    input  logic [reg_addr_w-1:0] id_ex_rd,
    input  logic                  id_ex_wr_reg_n,
    input  logic [xlen-1:0]       id_ex_a,
    input  logic [xlen-1:0]       id_ex_b,
    input  logic [xlen-1:0]       id_ex_imm,
    input  logic                  wb_valid,
    input  logic [reg_addr_w-1:0] wb_rd,
    input  logic [xlen-1:0]       wb_data,
    output logic                  ex_mem_valid,
    output logic [6:0]            ex_mem_opcode,
    output logic [reg_addr_w-1:0] ex_mem_rd,
    output logic                  ex_mem_wr_reg_n,
    output logic [reg_addr_w-1:0] ex_mem_rs2,
    output logic [xlen-1:0]       ex_mem_result,
    output logic [xlen-1:0]       ex_mem_store_data
);

    logic            mem_hit_a, mem_hit_b, wb_hit_a, wb_hit_b, ex_mem_is_load;
    logic [xlen-1:0] op_a, op_b, alu_b, alu_out;

    // producer sitting in the memory stage
    assign ex_mem_is_load = ex_mem_opcode == op_load;
    assign mem_hit_a = ex_mem_valid && !ex_mem_wr_reg_n && id_ex_rs1 != '0
                       && ex_mem_rd == id_ex_rs1;
    assign mem_hit_b = ex_mem_valid && !ex_mem_wr_reg_n && id_ex_rs2 != '0
                       && ex_mem_rd == id_ex_rs2;
    // producer on the write-back port, never x0
    assign wb_hit_a = wb_valid && id_ex_rs1 != '0 && wb_rd == id_ex_rs1;
    assign wb_hit_b = wb_valid && id_ex_rs2 != '0 && wb_rd == id_ex_rs2;

    // newest wins; a load in memory has only its address yet
    assign op_a = (mem_hit_a && !ex_mem_is_load) ? ex_mem_result :
                  wb_hit_a ? wb_data : id_ex_a;
    assign op_b = (mem_hit_b && !ex_mem_is_load) ? ex_mem_result :
                  wb_hit_b ? wb_data : id_ex_b;

    // immediate for addi, lw and sw address
    assign alu_b = (id_ex_opcode == op_reg) ? op_b : id_ex_imm;

    always_comb begin
        case (id_ex_funct3 & {3{id_ex_opcode == op_reg}})
            funct3_xor: alu_out = op_a ^ alu_b;
            funct3_or:  alu_out = op_a | alu_b;
            funct3_and: alu_out = op_a & alu_b;
            default:    alu_out = id_ex_sub ? op_a - alu_b : op_a + alu_b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem_valid    <= 1'b0;
            ex_mem_wr_reg_n <= 1'b1;
        end else begin
            ex_mem_valid    <= id_ex_valid;
            ex_mem_wr_reg_n <= id_ex_wr_reg_n | ~id_ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        ex_mem_opcode     <= id_ex_opcode;
        ex_mem_rd         <= id_ex_rd;
        ex_mem_rs2        <= id_ex_rs2;
        ex_mem_result     <= alu_out;
        // stale if rs2 is a load one ahead, memory stage fixes that
        ex_mem_store_data <= op_b;
    end

    // load data is not ready here, the stall detector must keep users apart
    a_no_load_fwd: assert property (@(posedge clk) disable iff (rst)
        (id_ex_valid && ex_mem_is_load) |->
            !mem_hit_a && !(mem_hit_b && id_ex_opcode != op_store));

endmodule

// ==== src/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage
    import rv_pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  ex_mem_valid,
    input  logic [6:0]            ex_mem_opcode,
    input  logic [reg_addr_w-1:0] ex_mem_rd,
    input  logic                  ex_mem_wr_reg_n,
    input  logic [reg_addr_w-1:0] ex_mem_rs2,
    input  logic [xlen-1:0]       ex_mem_result,
    input  logic [xlen-1:0]       ex_mem_store_data,
    output logic                  wb_valid,
    output logic [reg_addr_w-1:0] wb_rd,
    output logic [xlen-1:0]       wb_data
);

    logic [xlen-1:0]        dmem [dmem_words];
    logic [dmem_addr_w-1:0] word;
    logic [xlen-1:0]        store_data;
    logic                   is_load;

    // word index, byte offset dropped
    assign word    = ex_mem_result[dmem_addr_w+1:2];
    assign is_load = ex_mem_opcode == op_load;

    // load right before the store, its data is on the write-back port now
    assign store_data = (wb_valid && ex_mem_rs2 != '0 && wb_rd == ex_mem_rs2) ?
                        wb_data : ex_mem_store_data;

    always_ff @(posedge clk) begin
        if (ex_mem_valid && ex_mem_opcode == op_store) begin
            dmem[word] <= store_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= ex_mem_valid & ~ex_mem_wr_reg_n;
        end
    end

    // asynchronous read, registered into write-back
    always_ff @(posedge clk) begin
        wb_rd   <= ex_mem_rd;
        wb_data <= is_load ? dmem[word] : ex_mem_result;
    end

    // decode suppresses x0 destinations two stages earlier
    a_no_x0_wb: assert property (@(posedge clk) disable iff (rst)
        wb_valid |-> wb_rd != '0);

endmodule

// ==== src/rv_pipe_top.sv ====
`timescale 1ns/1ps

module rv_pipe_top
    import rv_pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  instr_t                in_instr,
    output logic                  in_ready,
    output logic                  wb_valid,
    output logic [reg_addr_w-1:0] wb_rd,
    output logic [xlen-1:0]       wb_data
);

    // decode side of the hazard check
    logic                  stall;
    logic [reg_addr_w-1:0] dec_rs1, dec_rs2;
    logic [6:0]            dec_opcode;

    // decode to execute
    logic                  id_ex_valid, id_ex_sub, id_ex_wr_reg_n;
    logic [6:0]            id_ex_opcode;
    logic [2:0]            id_ex_funct3;
    logic [reg_addr_w-1:0] id_ex_rs1, id_ex_rs2, id_ex_rd;
    logic [xlen-1:0]       id_ex_a, id_ex_b, id_ex_imm;

    // execute to memory
    logic                  ex_mem_valid, ex_mem_wr_reg_n;
    logic [6:0]            ex_mem_opcode;
    logic [reg_addr_w-1:0] ex_mem_rd, ex_mem_rs2;
    logic [xlen-1:0]       ex_mem_result, ex_mem_store_data;

    decode_stage decode_stage_i (.*);

    stall_detector stall_detector_i (.*);

    // write-back port feeds forwarding here and the register file in decode
    execute_stage execute_stage_i (.*);

    mem_stage mem_stage_i (.*);

endmodule

// ==== sim/wb_checker.sv ====
`timescale 1ns/1ps

module wb_checker
    import rv_pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  logic                  in_ready,
    input  logic                  wb_valid,
    input  logic [reg_addr_w-1:0] wb_rd,
    input  logic [xlen-1:0]       wb_data,
    output int                    wb_errors,
    output int                    stall_errors,
    output int                    pending
);

    // expected write-backs, oldest first
    logic [reg_addr_w-1:0] exp_rd[$];
    logic [xlen-1:0]       exp_data[$];
    int                    stall_cycles = 0;
    int                    exp_stalls = 0;

    task automatic expect_write(input logic [reg_addr_w-1:0] rd, input logic [xlen-1:0] data);
        exp_rd.push_back(rd);
        exp_data.push_back(data);
        pending = exp_rd.size();
    endtask

    task automatic expect_stalls(input int count);
        exp_stalls = count;
    endtask

    // dut outputs move on the rising edge, so sample on the falling one
    always @(negedge clk) begin
        if (!rst) begin
            // an offer that is refused is one stall cycle
            if (in_valid && !in_ready) begin
                stall_cycles++;
            end
            if (wb_valid && exp_rd.size() == 0) begin
                $display("write-back to x%0d arrived with none left to expect", wb_rd);
                wb_errors++;
            end else if (wb_valid) begin
                if (wb_rd !== exp_rd[0]) begin
                    $display("Mismatch wb_rd: expected 0x%h, got 0x%h", exp_rd[0], wb_rd);
                    wb_errors++;
                end
                if (wb_data !== exp_data[0]) begin
                    $display("Mismatch wb_data: expected 0x%h, got 0x%h", exp_data[0], wb_data);
                    wb_errors++;
                end
                void'(exp_rd.pop_front());
                void'(exp_data.pop_front());
                pending = exp_rd.size();
            end
        end
    end

    // end of run, pipeline already drained
    task automatic final_checks();
        if (exp_rd.size() != 0) begin
            $display("%0d expected write-backs never arrived, the first was to x%0d",
                     exp_rd.size(), exp_rd[0]);
            wb_errors++;
        end
        if (stall_cycles != exp_stalls) begin
            $display("Mismatch stall_cycles: expected 0x%h, got 0x%h", exp_stalls, stall_cycles);
            stall_errors++;
        end
    endtask

endmodule

// ==== sim/rv_pipe_tb.sv ====
`timescale 1ns/1ps

module rv_pipe_tb
    import rv_pipe_pkg::*;
();

    logic                  clk;
    logic                  rst;
    logic                  in_valid;
    instr_t                in_instr;
    logic                  in_ready;
    logic                  wb_valid;
    logic [reg_addr_w-1:0] wb_rd;
    logic [xlen-1:0]       wb_data;
    int                    wb_errors;
    int                    stall_errors;
    int                    pending;
    bit                    loaded;

    // program read from the data file with one gap per instruction
    int          gaps[$];
    logic [31:0] words[$];
    int          cycle_limit = 0;
    int          cycles = 0;

    rv_pipe_top rv_pipe_top_i (.*);

    wb_checker wb_checker_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // watchdog armed once the program length is known
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles with %0d write-backs still expected",
                     cycles, pending);
            $display("Finished with errors");
            $finish;
        end
    end

    // I lines feed the driver while W and S lines feed the checker
    task automatic load_program(output bit ok);
        int          fd;
        int          gap;
        int          rd;
        int          count;
        logic [31:0] value;
        string       line;
        fd = $fopen("sim/pipe_input.txt", "r");
        ok = fd != 0;
        if (ok) begin
            while ($fgets(line, fd) > 0) begin
                if ($sscanf(line, "I %d %h", gap, value) == 2) begin
                    gaps.push_back(gap);
                    words.push_back(value);
                end else if ($sscanf(line, "W %h %h", rd, value) == 2) begin
                    wb_checker_i.expect_write(rd[reg_addr_w-1:0], value);
                end else if ($sscanf(line, "S %d", count) == 1) begin
                    wb_checker_i.expect_stalls(count);
                end
            end
            $fclose(fd);
        end
    endtask

    // idle for gap cycles and then hold the word until it is accepted
    task automatic send(input int gap, input logic [31:0] word);
        logic taken;
        repeat (gap) begin
            @(posedge clk);
            #2;
        end
        in_valid = 1'b1;
        in_instr = word;
        // ready settles mid-cycle and the handshake completes at the next edge
        do begin
            @(negedge clk);
            taken = in_ready;
            @(posedge clk);
            #2;
        end while (!taken);
        in_valid = 1'b0;
        in_instr = '0;
    endtask

    initial begin
        rst      = 1'b1;
        in_valid = 1'b0;
        in_instr = '0;
        load_program(loaded);
        if (!loaded) begin
            $display("could not open the stimulus file sim/pipe_input.txt");
            $display("Finished with errors");
            $finish;
        end else begin
            cycle_limit = 20 * words.size() + 50;
            repeat (3) @(posedge clk);
            #2;
            rst = 1'b0;
            foreach (words[i]) begin
                send(gaps[i], words[i]);
            end
            // wait out the expected write-backs and one pipeline depth for strays
            while (pending != 0) begin
                @(posedge clk);
            end
            repeat (4) @(posedge clk);
            wb_checker_i.final_checks();
            #1;
            $display("errors: %0d write-back, %0d stall", wb_errors, stall_errors);
            if (wb_errors + stall_errors == 0) begin
                $display("Finished with no errors");
            end else begin
                $display("Finished with errors");
            end
            $finish;
        end
    end

endmodule

// ==== sim/pipe_input.txt ====
# I <idle cycles before offer> <instruction hex>   W <rd hex> <value hex>   S <stall cycles>
# each W line expects the write-back of the I line above it, x0 targets expect none
I 0 06400093  # addi x1, x0, 100
W 01 00000064
I 0 ff900113  # addi x2, x0, -7
W 02 fffffff9
I 3 002081b3  # add x3, x1, x2
W 03 0000005d
I 0 0020c2b3  # xor x5, x1, x2
W 05 ffffff9d
I 0 0020e333  # or x6, x1, x2
W 06 fffffffd
I 0 0020f3b3  # and x7, x1, x2
W 07 00000060
I 2 00400413  # addi x8, x0, 4   chain, back to back
W 08 00000004
I 0 008404b3  # add x9, x8, x8
W 09 00000008
I 0 40848533  # sub x10, x9, x8
W 0a 00000004
I 0 00902423  # sw x9, 8(x0)
I 0 00802603  # lw x12, 8(x0)
W 0c 00000008
I 0 001606b3  # add x13, x12, x1   load-use, one stall
W 0d 0000006c
I 0 00802703  # lw x14, 8(x0)
W 0e 00000008
I 1 40a707b3  # sub x15, x14, x10   one idle cycle, no stall
W 0f 00000004
I 0 00802803  # lw x16, 8(x0)
W 10 00000008
I 0 01002823  # sw x16, 16(x0)   store data from the load, no stall
I 0 01002883  # lw x17, 16(x0)
W 11 00000008
I 0 0018a223  # sw x1, 4(x17)   base from the load, one stall
I 0 00c02903  # lw x18, 12(x0)
W 12 00000064
I 0 00108013  # addi x0, x1, 1
I 0 00802003  # lw x0, 8(x0)
I 0 001009b3  # add x19, x0, x1
W 13 00000064
S 2

// ==== all.f ====
src/rv_pipe_pkg.sv
src/decode_stage.sv
src/stall_detector.sv
src/execute_stage.sv
src/mem_stage.sv
src/rv_pipe_top.sv
sim/wb_checker.sv
sim/rv_pipe_tb.sv

// ==== Bender.yml ====
package:
  name: rv_pipe

sources:
  - src/rv_pipe_pkg.sv
  - src/decode_stage.sv
  - src/stall_detector.sv
  - src/execute_stage.sv
  - src/mem_stage.sv
  - src/rv_pipe_top.sv
  - target: simulation
    files:
      - sim/wb_checker.sv
      - sim/rv_pipe_tb.sv
